// File: rtl/bpmRegPkg.sv
`default_nettype none

package bpmRegPkg;

    ////////////////////
    // Register bus geometry
    localparam int regDataWidth  = 32;
    localparam int regIndexWidth = 4;

    ////////////////////
    // Register map
    localparam logic [regIndexWidth-1:0] regUsSinceBoot      = regIndexWidth'(0);
    localparam logic [regIndexWidth-1:0] regSecondsSinceBoot = regIndexWidth'(1);
    localparam logic [regIndexWidth-1:0] regSoftTrigger      = regIndexWidth'(2);
    localparam logic [regIndexWidth-1:0] regHeartbeatReload  = regIndexWidth'(3);
    localparam logic [regIndexWidth-1:0] regFaReload         = regIndexWidth'(4);
    localparam logic [regIndexWidth-1:0] regSaReload         = regIndexWidth'(5);
    localparam logic [regIndexWidth-1:0] regInterlock        = regIndexWidth'(6);
    localparam logic [regIndexWidth-1:0] regUserStatus       = regIndexWidth'(7);
    localparam logic [regIndexWidth-1:0] regSpiMuxSel        = regIndexWidth'(8);

    // Number of mapped indices, everything above reads as zero
    localparam int regCount = 9;

endpackage

`default_nettype wire

// File: rtl/bpmTimingPkg.sv
`default_nettype none

package bpmTimingPkg;

    ////////////////////
    // Counter widths
    localparam int heartbeatWidth = 28;
    localparam int markerWidth    = 24;

    ////////////////////
    // Trigger bus
    // Bit 0 is the software trigger, the rest are event lines
    localparam int triggerBusWidth = 7;

    // Software trigger level length in sysClk cycles
    localparam int softTriggerStretch = 8;

    ////////////////////
    // Values after reset
    // Heartbeat once per second at 100 MHz
    localparam logic [heartbeatWidth-1:0] heartbeatReloadDefault =
        heartbeatWidth'(99_999_998);

    // FA at 10 kHz, SA at 10 Hz
    localparam logic [markerWidth-1:0] faReloadDefault = markerWidth'(9_999);
    localparam logic [markerWidth-1:0] saReloadDefault = markerWidth'(9_999_999);

endpackage

`default_nettype wire

// File: rtl/timingRegs.sv
`default_nettype none

module timingRegs (
    input  logic                                    sysClk,
    input  logic                                    rstN,
    input  logic [bpmRegPkg::regIndexWidth-1:0]     regIndex,
    input  logic                                    regWrite,
    input  logic [bpmRegPkg::regDataWidth-1:0]      regWriteData,
    output logic [bpmRegPkg::regDataWidth-1:0]      regReadData,
    input  logic [31:0]                             usSinceBoot,
    input  logic [31:0]                             secondsSinceBoot,
    input  logic [31:0]                             faStatus,
    input  logic [31:0]                             saStatus,
    input  logic                                    resetButton,
    input  logic                                    recoverySwitch,
    input  logic                                    displaySwitch,
    input  logic [7:0]                              dipSwitch,
    output logic [bpmTimingPkg::heartbeatWidth-1:0] heartbeatReload,
    output logic [bpmTimingPkg::markerWidth-1:0]    faReload,
    output logic [bpmTimingPkg::markerWidth-1:0]    saReload,
    output logic                                    faReloadWritten,
    output logic                                    saReloadWritten,
    output logic                                    softTriggerPulse,
    output logic                                    relayControl,
    output logic [1:0]                              spiMuxSel
);
    import bpmRegPkg::*;
    import bpmTimingPkg::*;

    logic        writeHeartbeat;
    logic        writeFa;
    logic        writeSa;
    logic        writeSoftTrigger;
    logic        writeInterlock;
    logic        writeSpiMux;
    logic [10:0] switchMeta;
    logic [10:0] switchSync;
    logic        resetButtonSync;
    logic        recoverySync;
    logic        displaySync;
    logic [7:0]  dipSync;

    ////////////////////
    // Write decode
    assign writeHeartbeat   = regWrite && (regIndex == regHeartbeatReload);
    assign writeFa          = regWrite && (regIndex == regFaReload);
    assign writeSa          = regWrite && (regIndex == regSaReload);
    assign writeSoftTrigger = regWrite && (regIndex == regSoftTrigger);
    assign writeInterlock   = regWrite && (regIndex == regInterlock);
    assign writeSpiMux      = regWrite && (regIndex == regSpiMuxSel);

    // Writable registers
    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            heartbeatReload <= heartbeatReloadDefault;
            faReload        <= faReloadDefault;
            saReload        <= saReloadDefault;
            relayControl    <= 1'b0;
            spiMuxSel       <= 2'b00;
        end else begin
            if (writeHeartbeat) begin
                heartbeatReload <= regWriteData[heartbeatWidth-1:0];
            end
            if (writeFa) begin
                faReload <= regWriteData[markerWidth-1:0];
            end
            if (writeSa) begin
                saReload <= regWriteData[markerWidth-1:0];
            end
            if (writeInterlock) begin
                relayControl <= regWriteData[0];
            end
            if (writeSpiMux) begin
                spiMuxSel <= regWriteData[1:0];
            end
        end
    end

    // Notifications, one cycle after the write
    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            faReloadWritten  <= 1'b0;
            saReloadWritten  <= 1'b0;
            softTriggerPulse <= 1'b0;
        end else begin
            faReloadWritten  <= writeFa;
            saReloadWritten  <= writeSa;
            softTriggerPulse <= writeSoftTrigger;
        end
    end

    ////////////////////
    // Front panel and DIP switches, two-flop synchronizer
    always_ff @(posedge sysClk) begin
        switchMeta <= {resetButton, recoverySwitch, displaySwitch, dipSwitch};
        switchSync <= switchMeta;
    end

    assign resetButtonSync = switchSync[10];
    assign recoverySync    = switchSync[9];
    assign displaySync     = switchSync[8];
    assign dipSync         = switchSync[7:0];

    ////////////////////
    // Readback
    always_comb begin
        case (regIndex)
            regUsSinceBoot:      regReadData = usSinceBoot;
            regSecondsSinceBoot: regReadData = secondsSinceBoot;
            regHeartbeatReload:  regReadData = regDataWidth'(heartbeatReload);
            regFaReload:         regReadData = faStatus;
            regSaReload:         regReadData = saStatus;
            regInterlock:
                regReadData = regDataWidth'({relayControl, 3'b000, resetButtonSync});
            regUserStatus:       regReadData = {recoverySync, displaySync, 22'b0, dipSync};
            regSpiMuxSel:        regReadData = regDataWidth'(spiMuxSel);
            default:             regReadData = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/uptimeCounters.sv
`default_nettype none

module uptimeCounters #(
    parameter int ticksPerMicrosecond   = 100,
    parameter int microsecondsPerSecond = 1000000
) (
    input  logic        sysClk,
    input  logic        rstN,
    output logic [31:0] usSinceBoot,
    output logic [31:0] secondsSinceBoot
);

    localparam int tickWidth = $clog2(ticksPerMicrosecond + 1);
    localparam int usWidth   = $clog2(microsecondsPerSecond + 1);

    logic [tickWidth-1:0] tickCount;
    logic                 usTick;
    logic [usWidth-1:0]   usInSecond;
    logic                 secondDone;

    assign usTick     = (tickCount == tickWidth'(ticksPerMicrosecond - 1));
    assign secondDone = (usInSecond == usWidth'(microsecondsPerSecond - 1));

    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            tickCount        <= '0;
            usInSecond       <= '0;
            usSinceBoot      <= '0;
            secondsSinceBoot <= '0;
        end else if (usTick) begin
            tickCount   <= '0;
            usSinceBoot <= usSinceBoot + 32'd1;
            // Seconds advance together with the microsecond that completes them
            if (secondDone) begin
                usInSecond       <= '0;
                secondsSinceBoot <= secondsSinceBoot + 32'd1;
            end else begin
                usInSecond <= usInSecond + usWidth'(1);
            end
        end else begin
            tickCount <= tickCount + tickWidth'(1);
        end
    end

endmodule

`default_nettype wire

// File: rtl/heartbeatGen.sv
`default_nettype none

module heartbeatGen (
    input  logic                                    sysClk,
    input  logic                                    rstN,
    input  logic [bpmTimingPkg::heartbeatWidth-1:0] heartbeatReload,
    output logic                                    heartbeat
);
    import bpmTimingPkg::*;

    // Extra top bit goes high when the count passes zero
    logic [heartbeatWidth:0] counter;
    logic                    counterDone;

    assign counterDone = counter[heartbeatWidth];
    assign heartbeat   = counterDone;

    // Reload, count down to zero, one done cycle
    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            counter <= {1'b0, heartbeatReload};
        end else if (counterDone) begin
            counter <= {1'b0, heartbeatReload};
        end else begin
            counter <= counter - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/markerDivider.sv
`default_nettype none

module markerDivider (
    input  logic                                 sysClk,
    input  logic                                 rstN,
    input  logic                                 heartbeat,
    input  logic [bpmTimingPkg::markerWidth-1:0] reload,
    input  logic                                 reloadWritten,
    output logic                                 marker,
    output logic [31:0]                          status
);
    import bpmTimingPkg::*;

    logic [markerWidth-1:0] counter;
    logic                   counterZero;
    logic                   synced;

    assign counterZero = (counter == '0);

    // Heartbeat forces a marker and restarts the division
    assign marker = heartbeat || counterZero;

    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            counter <= reload;
        end else if (heartbeat || counterZero) begin
            counter <= reload;
        end else begin
            counter <= counter - 1'b1;
        end
    end

    ////////////////////
    // Lock indication
    // Synced when the heartbeat lands exactly on a divider boundary
    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            synced <= 1'b0;
        end else if (reloadWritten) begin
            synced <= 1'b0;
        end else if (heartbeat) begin
            synced <= counterZero;
        end
    end

    // Synced flag on top, reload in the low bits
    assign status = {synced, {(31 - markerWidth){1'b0}}, reload};

endmodule

`default_nettype wire

// File: rtl/triggerCapture.sv
`default_nettype none

module triggerCapture (
    input  logic                                     sysClk,
    input  logic                                     rstN,
    input  logic                                     softTriggerPulse,
    input  logic [bpmTimingPkg::triggerBusWidth-2:0] eventTriggers,
    output logic [bpmTimingPkg::triggerBusWidth-1:0] triggerStrobes
);
    import bpmTimingPkg::*;

    localparam int stretchWidth = $clog2(softTriggerStretch + 1);

    logic [stretchWidth-1:0]    stretchCount;
    logic                       softTriggerLevel;
    logic [triggerBusWidth-2:0] eventMeta;
    logic [triggerBusWidth-2:0] eventSync;
    logic [triggerBusWidth-1:0] triggerBus;
    logic [triggerBusWidth-1:0] triggerBusDelay;

    ////////////////////
    // Software trigger stretcher
    assign softTriggerLevel = (stretchCount != '0);

    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            stretchCount <= '0;
        end else if (softTriggerPulse) begin
            stretchCount <= stretchWidth'(softTriggerStretch);
        end else if (softTriggerLevel) begin
            stretchCount <= stretchCount - 1'b1;
        end
    end

    ////////////////////
    // Event lines are asynchronous
    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            eventMeta <= '0;
            eventSync <= '0;
        end else begin
            eventMeta <= eventTriggers;
            eventSync <= eventMeta;
        end
    end

    assign triggerBus = {eventSync, softTriggerLevel};

    // Rising edge detect, one strobe per edge
    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            triggerBusDelay <= '0;
            triggerStrobes  <= '0;
        end else begin
            triggerBusDelay <= triggerBus;
            triggerStrobes  <= triggerBus & ~triggerBusDelay;
        end
    end

endmodule

`default_nettype wire

// File: rtl/bpmTimingTop.sv
`default_nettype none

module bpmTimingTop #(
    parameter int ticksPerMicrosecond   = 100,
    parameter int microsecondsPerSecond = 1000000
) (
    input  logic                                     sysClk,
    input  logic                                     rstN,
    input  logic [bpmRegPkg::regIndexWidth-1:0]      regIndex,
    input  logic                                     regWrite,
    input  logic [bpmRegPkg::regDataWidth-1:0]       regWriteData,
    output logic [bpmRegPkg::regDataWidth-1:0]       regReadData,
    input  logic [bpmTimingPkg::triggerBusWidth-2:0] eventTriggers,
    input  logic                                     resetButton,
    input  logic                                     recoverySwitch,
    input  logic                                     displaySwitch,
    input  logic [7:0]                               dipSwitch,
    output logic                                     heartbeat,
    output logic                                     faMarker,
    output logic                                     saMarker,
    output logic [bpmTimingPkg::triggerBusWidth-1:0] triggerStrobes,
    output logic                                     relayControl,
    output logic [1:0]                               clkSpiMuxSel,
    output logic [7:0]                               leds
);
    import bpmTimingPkg::*;

    logic [31:0]               usSinceBoot;
    logic [31:0]               secondsSinceBoot;
    logic [31:0]               faStatus;
    logic [31:0]               saStatus;
    logic [heartbeatWidth-1:0] heartbeatReload;
    logic [markerWidth-1:0]    faReload;
    logic [markerWidth-1:0]    saReload;
    logic                      faReloadWritten;
    logic                      saReloadWritten;
    logic                      softTriggerPulse;
    logic [1:0]                spiMuxSel;

    ////////////////////
    // Register block
    timingRegs timingRegs_i (
        .sysClk           (sysClk),
        .rstN             (rstN),
        .regIndex         (regIndex),
        .regWrite         (regWrite),
        .regWriteData     (regWriteData),
        .regReadData      (regReadData),
        .usSinceBoot      (usSinceBoot),
        .secondsSinceBoot (secondsSinceBoot),
        .faStatus         (faStatus),
        .saStatus         (saStatus),
        .resetButton      (resetButton),
        .recoverySwitch   (recoverySwitch),
        .displaySwitch    (displaySwitch),
        .dipSwitch        (dipSwitch),
        .heartbeatReload  (heartbeatReload),
        .faReload         (faReload),
        .saReload         (saReload),
        .faReloadWritten  (faReloadWritten),
        .saReloadWritten  (saReloadWritten),
        .softTriggerPulse (softTriggerPulse),
        .relayControl     (relayControl),
        .spiMuxSel        (spiMuxSel)
    );

    ////////////////////
    // Timekeeping
    uptimeCounters #(
        .ticksPerMicrosecond   (ticksPerMicrosecond),
        .microsecondsPerSecond (microsecondsPerSecond)
    ) uptimeCounters_i (
        .sysClk           (sysClk),
        .rstN             (rstN),
        .usSinceBoot      (usSinceBoot),
        .secondsSinceBoot (secondsSinceBoot)
    );

    heartbeatGen heartbeatGen_i (
        .sysClk          (sysClk),
        .rstN            (rstN),
        .heartbeatReload (heartbeatReload),
        .heartbeat       (heartbeat)
    );

    // FA and SA markers, both locked to the heartbeat
    markerDivider faDivider (
        .sysClk        (sysClk),
        .rstN          (rstN),
        .heartbeat     (heartbeat),
        .reload        (faReload),
        .reloadWritten (faReloadWritten),
        .marker        (faMarker),
        .status        (faStatus)
    );

    markerDivider saDivider (
        .sysClk        (sysClk),
        .rstN          (rstN),
        .heartbeat     (heartbeat),
        .reload        (saReload),
        .reloadWritten (saReloadWritten),
        .marker        (saMarker),
        .status        (saStatus)
    );

    ////////////////////
    // Triggers
    triggerCapture triggerCapture_i (
        .sysClk           (sysClk),
        .rstN             (rstN),
        .softTriggerPulse (softTriggerPulse),
        .eventTriggers    (eventTriggers),
        .triggerStrobes   (triggerStrobes)
    );

    assign clkSpiMuxSel = spiMuxSel;

    ////////////////////
    // Front panel LEDs
    assign leds[0]   = faStatus[31];
    assign leds[1]   = saStatus[31];
    assign leds[3:2] = secondsSinceBoot[1:0];
    assign leds[7:4] = 4'b0000;

endmodule

`default_nettype wire

// File: dv/bpmTimingTb.sv
`default_nettype none

module bpmTimingTb;
    import bpmRegPkg::*;
    import bpmTimingPkg::*;

    localparam int ticksPerUs  = 4;
    localparam int usPerSecond = 5;
    localparam int hbReload    = 22;
    localparam int hbPeriod    = hbReload + 2;
    localparam int rowCount    = 8;
    localparam int eventTrials = 8;
    localparam int uptimeReads = 6;
    // Reset, table, heartbeats, triggers, uptime reads, idle span and slack
    localparam int cycleLimit  = 24 + rowCount * 6 + 20 + 3 * hbPeriod + eventTrials * 6
        + 2 * 20 + uptimeReads * 20 + 404 + 100;

    logic                       sysClk = 1'b0;
    logic                       rstN;
    logic [regIndexWidth-1:0]   regIndex;
    logic                       regWrite;
    logic [regDataWidth-1:0]    regWriteData;
    logic [regDataWidth-1:0]    regReadData;
    logic [triggerBusWidth-2:0] eventTriggers;
    logic                       resetButton;
    logic                       recoverySwitch;
    logic                       displaySwitch;
    logic [7:0]                 dipSwitch;
    logic                       heartbeat;
    logic                       faMarker;
    logic                       saMarker;
    logic [triggerBusWidth-1:0] triggerStrobes;
    logic                       relayControl;
    logic [1:0]                 clkSpiMuxSel;
    logic [7:0]                 leds;
    int                         cycleCount  = 0;
    int                         errorCount  = 0;
    int                         testCount   = 0;
    int                         failedTests = 0;
    logic [31:0]                lfsr        = 32'hf97e;

    ////////////////////
    // Register table, written then read back
    string rowName [rowCount] = '{"heartbeat reload", "fa reload", "sa reload",
        "spi mux select", "interlock set", "spi mux wide", "interlock clear", "unmapped index"};
    logic [regIndexWidth-1:0] rowIndex [rowCount] = '{regHeartbeatReload, regFaReload,
        regSaReload, regSpiMuxSel, regInterlock, regSpiMuxSel, regInterlock, 4'hc};
    logic [31:0] rowData [rowCount] = '{32'(hbReload), 32'd5, 32'd6, 32'd2, 32'd1,
        32'hffff_fffd, 32'hffff_fffe, 32'h5a5a_5a5a};
    logic [31:0] rowExpect [rowCount] = '{32'(hbReload), 32'd5, 32'd6, 32'd2, 32'h10,
        32'd1, 32'd0, 32'd0};

    bpmTimingTop #(
        .ticksPerMicrosecond   (ticksPerUs),
        .microsecondsPerSecond (usPerSecond)
    ) bpmTimingTop_i (.*);

    always #10 sysClk = ~sysClk;

    always @(posedge sysClk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Galois LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s: expected %h, got %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic endTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("ok     %s", name);
        end else begin
            failedTests++;
            $display("failed %s with %0d bad checks", name, errorCount - errorsBefore);
        end
    endtask

    task automatic writeReg(input logic [3:0] index, input logic [31:0] data);
        @(negedge sysClk);
        regIndex     = index;
        regWrite     = 1'b1;
        regWriteData = data;
        @(negedge sysClk);
        regWrite = 1'b0;
    endtask

    // Readback is combinational, sampled one cycle after the index settles
    task automatic readReg(input logic [3:0] index, output logic [31:0] data);
        @(negedge sysClk);
        regIndex = index;
        @(negedge sysClk);
        data = regReadData;
    endtask

    task automatic waitHeartbeat();
        @(negedge sysClk);
        while (!heartbeat) begin
            @(negedge sysClk);
        end
    endtask

    initial begin
        logic [31:0] value;
        logic [31:0] usValue;
        logic [31:0] previousUs;
        logic [31:0] previousSec;
        logic [10:0] switches;
        logic [5:0]  pattern;
        int          mark;
        int          hbCycle;
        int          markerCount;
        int          lastMarker;
        int          saCount;
        int          lastSa;
        int          strobeCount;

        rstN           = 1'b0;
        regIndex       = '0;
        regWrite       = 1'b0;
        regWriteData   = '0;
        eventTriggers  = '0;
        resetButton    = 1'b0;
        recoverySwitch = 1'b0;
        displaySwitch  = 1'b0;
        dipSwitch      = '0;
        repeat (16) @(negedge sysClk);
        rstN = 1'b1;

        // Heartbeat counter reloads only at its terminal count
        // A one-cycle reset loads it straight from the new reload
        writeReg(regHeartbeatReload, 32'(hbReload));
        rstN = 1'b0;
        @(negedge sysClk);
        rstN = 1'b1;

        for (int row = 0; row < rowCount; row++) begin
            mark = errorCount;
            writeReg(rowIndex[row], rowData[row]);
            readReg(rowIndex[row], value);
            checkValue(rowName[row], rowExpect[row], value);
            if (rowIndex[row] == regSpiMuxSel) begin
                checkValue(rowName[row], rowData[row] & 32'h3, {30'b0, clkSpiMuxSel});
            end
            if (rowIndex[row] == regInterlock) begin
                checkValue(rowName[row], rowData[row] & 32'h1, {31'b0, relayControl});
            end
            endTest(rowName[row], mark);
        end

        // Switches pass two synchronizer flops before readback
        mark     = errorCount;
        switches = 11'(takeBits(11));
        @(negedge sysClk);
        {resetButton, recoverySwitch, displaySwitch, dipSwitch} = switches;
        repeat (3) @(negedge sysClk);
        readReg(regUserStatus, value);
        checkValue("user status", {switches[9], switches[8], 22'b0, switches[7:0]}, value);
        readReg(regInterlock, value);
        checkValue("user status", {31'b0, switches[10]}, value);
        endTest("user status", mark);

        ////////////////////
        // Heartbeat and marker dividers
        mark = errorCount;
        waitHeartbeat();
        hbCycle = cycleCount;
        waitHeartbeat();
        checkValue("heartbeat period", 32'(hbPeriod), 32'(cycleCount - hbCycle));
        endTest("heartbeat period", mark);

        // FA reload 5 gives a marker every 6 cycles, SA reload 6 every 7
        mark        = errorCount;
        markerCount = 0;
        lastMarker  = 0;
        saCount     = 0;
        lastSa      = 0;
        for (int i = 0; i < hbPeriod; i++) begin
            if (faMarker) begin
                if (markerCount > 0) begin
                    checkValue("marker dividers", 32'd6, 32'(i - lastMarker));
                end
                markerCount++;
                lastMarker = i;
            end
            if (saMarker) begin
                if (saCount > 0) begin
                    checkValue("marker dividers", 32'd7, 32'(i - lastSa));
                end
                saCount++;
                lastSa = i;
            end
            @(negedge sysClk);
        end
        checkValue("marker dividers", 32'd4, 32'(markerCount));
        checkValue("marker dividers", 32'd4, 32'(saCount));
        readReg(regFaReload, value);
        checkValue("marker dividers", 32'h8000_0005, value);
        readReg(regSaReload, value);
        checkValue("marker dividers", 32'h0000_0006, value);
        checkValue("marker dividers", 32'h1, {30'b0, leds[1:0]});
        endTest("marker dividers", mark);

        ////////////////////
        // Triggers
        mark = errorCount;
        for (int trial = 0; trial < eventTrials; trial++) begin
            pattern       = 6'(takeBits(6));
            eventTriggers = pattern;
            for (int i = 1; i <= 6; i++) begin
                @(negedge sysClk);
                if (i == 2) begin
                    eventTriggers = '0;
                end
                value = (i == 3) ? {25'b0, pattern, 1'b0} : 32'd0;
                checkValue("event triggers", value, {25'b0, triggerStrobes});
            end
        end
        endTest("event triggers", mark);

        mark = errorCount;
        for (int shot = 0; shot < 2; shot++) begin
            strobeCount = 0;
            writeReg(regSoftTrigger, 32'h1);
            repeat (16) begin
                @(negedge sysClk);
                strobeCount += int'(triggerStrobes[0]);
            end
            checkValue("software trigger", 32'd1, 32'(strobeCount));
        end
        endTest("software trigger", mark);

        ////////////////////
        // Uptime
        mark        = errorCount;
        previousUs  = '0;
        previousSec = '0;
        for (int n = 0; n < uptimeReads; n++) begin
            repeat (takeBits(4)) @(negedge sysClk);
            readReg(regUsSinceBoot, usValue);
            readReg(regSecondsSinceBoot, value);
            // A second may roll over between the two reads
            assert (value == usValue / usPerSecond || value == usValue / usPerSecond + 1)
            else begin
                $display("FAIL uptime: expected %0d or %0d, got %0d",
                         usValue / usPerSecond, usValue / usPerSecond + 1, value);
                errorCount++;
            end
            assert (usValue >= previousUs && value >= previousSec) else begin
                $display("FAIL uptime: a counter went backwards");
                errorCount++;
            end
            // LEDs 3:2 show the low seconds bits, 7:4 stay dark
            checkValue("uptime", {26'b0, 4'b0000, value[1:0]}, {26'b0, leds[7:2]});
            previousUs  = usValue;
            previousSec = value;
        end
        readReg(regUsSinceBoot, previousUs);
        repeat (398) @(negedge sysClk);
        readReg(regUsSinceBoot, usValue);
        assert (usValue - previousUs >= 99 && usValue - previousUs <= 101) else begin
            $display("FAIL uptime: expected 100, got %0d", usValue - previousUs);
            errorCount++;
        end
        endTest("uptime", mark);

        $display("Summary: %0d tests, %0d failed, %0d bad checks",
                 testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
rtl/bpmRegPkg.sv
rtl/bpmTimingPkg.sv
rtl/timingRegs.sv
rtl/uptimeCounters.sv
rtl/heartbeatGen.sv
rtl/markerDivider.sv
rtl/triggerCapture.sv
rtl/bpmTimingTop.sv
dv/bpmTimingTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= bpmTimingTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
